// ==== argmaxSelect.sv ====
`timescale 1ns/1ps

module argmaxSelect (
	input logic clk,
	input logic reset,
	input mlpPkg::scoreVec rawScores,
	output mlpPkg::scoreVec scores,
	output logic [mlpPkg::classIndexWidth-1:0] classIndex
);

	localparam int indexWidth = mlpPkg::classIndexWidth;

	logic [indexWidth-1:0] bestIdx;
	mlpPkg::fixedVal bestVal;

	// walk the scores from class 0 upwards and keep the running best
	always_comb
	begin
		bestIdx = '0;
		bestVal = rawScores.value[0];
		for (int i = 1; i < mlpPkg::numClasses; i++)
		begin
			// strict compare so an equal later score never replaces an earlier one
			if (rawScores.value[i] > bestVal)
			begin
				bestIdx = indexWidth'(i);
				bestVal = rawScores.value[i];
			end
		end
	end

	// scores and index are registered together so they always describe one vector
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scores <= '0;
			classIndex <= '0;
		end
		else
		begin
			scores <= rawScores;
			classIndex <= bestIdx;
		end
	end

endmodule

// ==== denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer #(
	parameter int fanIn = 15,
	parameter int width = 6,
	parameter mlpPkg::fixedVal [width-1:0][fanIn-1:0] weightTable = '0,
	parameter mlpPkg::fixedVal [width-1:0] biasTable = '0,
	parameter int scaleShift = 7,
	parameter bit useClamp = 1'b1
) (
	input logic clk,
	input logic reset,
	input mlpPkg::fixedVal [fanIn-1:0] layerIn,
	output mlpPkg::fixedVal [width-1:0] layerOut
);

	// row n of the weight table and entry n of the bias table belong to neuron n,
	// and every neuron sees the same layer input
	for (genvar n = 0; n < width; n++)
	begin : gNode
		neuronNode #(
			.fanIn(fanIn),
			.weights(weightTable[n]),
			.bias(biasTable[n]),
			.scaleShift(scaleShift),
			.useClamp(useClamp)
		) i_neuronNode (
			.clk(clk),
			.reset(reset),
			.inputs(layerIn),
			.activation(layerOut[n]) // neuron n lands in element n
		);
	end

endmodule

// ==== mlpChecker.sv ====
`timescale 1ns/1ps

module mlpChecker #(
	parameter int latency = 7
) (
	input logic clk,
	input logic reset,
	input mlpPkg::scoreVec scores,
	input logic [mlpPkg::classIndexWidth-1:0] classIndex,
	input logic expValid,
	input mlpPkg::scoreVec expScores,
	input logic [mlpPkg::classIndexWidth-1:0] expClass,
	input logic reportNow,
	output int checkedCount,
	output int errorCount
);

	// one expected result waiting for its vector to leave the pipeline
	typedef struct packed
	{
		mlpPkg::scoreVec scores;
		logic [mlpPkg::classIndexWidth-1:0] classIdx;
		int id;
		int due;
	} expectEntry;

	expectEntry pending[$];
	expectEntry entry;
	int cycle;
	int pushed;
	int passCount;
	logic resetChecked;

	// right after reset nothing has reached the outputs yet
	task automatic checkResetState();
		if (scores !== '0 || classIndex !== '0)
		begin
			$display("mismatch after reset scores expected %h actual %h class expected 0 actual %0d",
				32'h0, scores, classIndex);
			errorCount++;
		end
		else
		begin
			$display("ok after reset scores %h class %0d", scores, classIndex);
			passCount++;
		end
		checkedCount++;
	endtask

	task automatic checkVector(input expectEntry e);
		logic ok;
		ok = 1'b1;
		if (scores !== e.scores)
		begin
			$display("mismatch vector %0d scores expected %h actual %h", e.id, e.scores, scores);
			ok = 1'b0;
		end
		if (classIndex !== e.classIdx)
		begin
			$display("mismatch vector %0d class expected %0d actual %0d", e.id, e.classIdx,
				classIndex);
			ok = 1'b0;
		end
		if (ok)
		begin
			$display("ok vector %0d scores %h class %0d", e.id, scores, classIndex);
			passCount++;
		end
		else
		begin
			errorCount++;
		end
		checkedCount++;
	endtask

	// outputs change on the rising edge, so they are compared on the falling one
	always @(negedge clk)
	begin
		if (reset)
		begin
			pending.delete();
			resetChecked = 1'b0;
			checkedCount = 0;
			errorCount = 0;
			passCount = 0;
			pushed = 0;
			cycle = 0;
		end
		else
		begin
			if (!resetChecked)
			begin
				checkResetState();
				resetChecked = 1'b1;
			end
			if (pending.size() > 0 && pending[0].due == cycle)
			begin
				checkVector(pending.pop_front());
			end
			if (expValid)
			begin
				entry.scores = expScores;
				entry.classIdx = expClass;
				entry.id = pushed;
				entry.due = cycle + latency; // vector is taken at the next rising edge
				pending.push_back(entry);
				pushed++;
			end
			cycle++;
		end
	end

	always @(posedge reportNow)
	begin
		$display("tests %0d passed %0d failed %0d still pending %0d", checkedCount, passCount,
			errorCount, pending.size());
	end

endmodule

// ==== mlpClassifier.sv ====
`timescale 1ns/1ps

// weight tables are packed arrays, so in every list the highest index comes first:
// neuron 5 down to neuron 0 for the rows, feature 14 down to feature 0 inside a row
module mlpClassifier #(
	parameter mlpPkg::fixedVal [mlpPkg::numHidden-1:0][mlpPkg::numFeatures-1:0]
		hiddenWeights = '{
		'{8'sd41, -8'sd6, 8'sd22, -8'sd18, 8'sd30, 8'sd15, -8'sd40, 8'sd27,
			-8'sd9, 8'sd38, -8'sd21, 8'sd7, 8'sd45, -8'sd33, 8'sd12},
		'{-8'sd12, 8'sd24, -8'sd38, 8'sd9, -8'sd27, 8'sd20, 8'sd33, -8'sd15,
			8'sd11, -8'sd44, 8'sd29, 8'sd36, -8'sd8, 8'sd17, -8'sd25},
		'{8'sd18, -8'sd37, 8'sd6, 8'sd43, -8'sd19, 8'sd31, -8'sd5, -8'sd26,
			8'sd35, 8'sd14, 8'sd8, -8'sd30, -8'sd17, 8'sd22, 8'sd40},
		'{-8'sd34, 8'sd13, 8'sd21, -8'sd29, 8'sd37, -8'sd10, 8'sd16, 8'sd32,
			-8'sd23, 8'sd5, -8'sd48, 8'sd19, 8'sd26, -8'sd39, -8'sd14},
		'{8'sd9, 8'sd39, -8'sd20, 8'sd15, -8'sd7, 8'sd42, -8'sd36, 8'sd4,
			8'sd25, -8'sd31, 8'sd17, -8'sd22, 8'sd34, 8'sd10, 8'sd28},
		'{-8'sd60, -8'sd15, -8'sd43, 8'sd38, 8'sd51, -8'sd63, -8'sd3, -8'sd23,
			8'sd31, -8'sd45, -8'sd27, -8'sd5, 8'sd36, 8'sd30, -8'sd57}
	},
	parameter mlpPkg::fixedVal [mlpPkg::numHidden-1:0] hiddenBias = '{
		8'sd4, -8'sd3, 8'sd8, 8'sd0, -8'sd6, 8'sd2
	},
	// output weights are large on purpose, a few strong hidden units can pin a score
	parameter mlpPkg::fixedVal [mlpPkg::numClasses-1:0][mlpPkg::numHidden-1:0]
		outWeights = '{
		'{8'sd96, -8'sd80, 8'sd54, -8'sd110, 8'sd72, 8'sd30},
		'{-8'sd64, 8'sd101, -8'sd45, 8'sd88, -8'sd20, 8'sd77},
		'{8'sd115, 8'sd40, -8'sd92, 8'sd25, 8'sd60, -8'sd70},
		'{-8'sd35, -8'sd58, 8'sd120, 8'sd47, -8'sd99, 8'sd83}
	},
	parameter mlpPkg::fixedVal [mlpPkg::numClasses-1:0] outBias = '{
		8'sd5, -8'sd2, 8'sd0, 8'sd3
	},
	parameter int scaleShift = 7
) (
	input logic clk,
	input logic reset,
	input mlpPkg::featureVec features,
	output mlpPkg::scoreVec scores,
	output logic [mlpPkg::classIndexWidth-1:0] classIndex
);

	mlpPkg::hiddenVec hidden;
	mlpPkg::scoreVec rawScores;

	// hidden layer clamps negative sums to zero
	denseLayer #(
		.fanIn(mlpPkg::numFeatures),
		.width(mlpPkg::numHidden),
		.weightTable(hiddenWeights),
		.biasTable(hiddenBias),
		.scaleShift(scaleShift),
		.useClamp(1'b1)
	) i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.layerIn(features.value),
		.layerOut(hidden.value)
	);

	// output layer keeps the sign and saturates both ways
	denseLayer #(
		.fanIn(mlpPkg::numHidden),
		.width(mlpPkg::numClasses),
		.weightTable(outWeights),
		.biasTable(outBias),
		.scaleShift(scaleShift),
		.useClamp(1'b0)
	) i_outputLayer (
		.clk(clk),
		.reset(reset),
		.layerIn(hidden.value),
		.layerOut(rawScores.value)
	);

	argmaxSelect i_argmaxSelect (
		.clk(clk),
		.reset(reset),
		.rawScores(rawScores),
		.scores(scores),
		.classIndex(classIndex) // seventh register stage
	);

endmodule

// ==== mlpPkg.sv ====
package mlpPkg;

	// fixed point format shared by features, activations and weights
	localparam int featureWidth = 8;

	// 15 products of 8x8 bits plus the scaled bias fit in 20 signed bits
	localparam int accWidth = 20;

	// network shape
	localparam int numFeatures = 15;
	localparam int numHidden = 6;
	localparam int numClasses = 4;

	// enough bits to number every output class
	localparam int classIndexWidth = 2;

	// one signed 8-bit value, the element type of every vector below
	typedef logic signed [featureWidth-1:0] fixedVal;

	// input sample, element 0 is feature 0
	typedef struct packed
	{
		fixedVal [numFeatures-1:0] value;
	} featureVec;

	// hidden layer activations after the clamp to zero
	typedef struct packed
	{
		fixedVal [numHidden-1:0] value;
	} hiddenVec;

	// output layer scores after saturation
	typedef struct packed
	{
		fixedVal [numClasses-1:0] value;
	} scoreVec;

endpackage

// ==== mlpStim.mem ====
// columns: features 0 to 14, expected scores of classes 0 to 3, expected class
// all values are 8-bit two's complement hex, one test vector per line
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0A FC FA 0B 03
40 00 00 00 00 00 00 00 00 00 00 00 00 00 00 14 F8 ED 1C 03
00 00 00 00 00 00 00 00 00 C0 00 00 00 00 00 1A EE 15 08 00
00 00 40 00 00 00 00 00 00 00 00 00 00 00 00 05 14 04 18 03
00 00 00 64 00 00 00 00 00 00 00 00 CE 00 00 FC 05 29 EA 02
00 00 00 00 00 00 00 00 50 00 00 00 00 00 D8 0C 00 27 EA 02
// every hidden sum goes negative here, so only the output biases remain
00 00 EA 00 16 00 EA 00 00 00 00 EA 00 00 00 03 00 FE 05 03
7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F E8 55 9A 7F 03
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 5F C0 5D 0A 00
00 7F 00 00 00 00 7F 81 00 00 00 7F 00 81 00 7F 80 30 49 00
// classes 0 and 3 both saturate, class 0 has to win the tie
00 7F 7F 00 00 7F 7F 81 00 00 7F 7F 00 81 7F 7F A9 F2 7F 00
7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F E8 55 9A 7F 03
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 5F C0 5D 0A 00
7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F E8 55 9A 7F 03
00 00 EA 00 16 00 EA 00 00 00 00 EA 00 00 00 03 00 FE 05 03
00 7F 7F 00 00 7F 7F 81 00 00 7F 7F 00 81 7F 7F A9 F2 7F 00
40 00 00 00 00 00 00 00 00 00 00 00 00 00 00 14 F8 ED 1C 03
00 7F 00 00 00 00 7F 81 00 00 00 7F 00 81 00 7F 80 30 49 00
00 00 00 00 00 00 00 00 00 C0 00 00 00 00 00 1A EE 15 08 00
00 00 00 00 00 00 00 00 50 00 00 00 00 00 D8 0C 00 27 EA 02
00 00 00 64 00 00 00 00 00 00 00 00 CE 00 00 FC 05 29 EA 02
00 00 40 00 00 00 00 00 00 00 00 00 00 00 00 05 14 04 18 03
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0A FC FA 0B 03
00 00 EA 00 16 00 EA 00 00 00 00 EA 00 00 00 03 00 FE 05 03
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 5F C0 5D 0A 00
00 7F 7F 00 00 7F 7F 81 00 00 7F 7F 00 81 7F 7F A9 F2 7F 00
00 7F 00 00 00 00 7F 81 00 00 00 7F 00 81 00 7F 80 30 49 00
7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F E8 55 9A 7F 03
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0A FC FA 0B 03

// ==== neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode #(
	parameter int fanIn = 15,
	parameter mlpPkg::fixedVal [fanIn-1:0] weights = '0,
	parameter mlpPkg::fixedVal bias = '0,
	parameter int scaleShift = 7,
	parameter bit useClamp = 1'b1
) (
	input logic clk,
	input logic reset,
	input mlpPkg::fixedVal [fanIn-1:0] inputs,
	output logic signed [mlpPkg::featureWidth-1:0] activation
);

	localparam int accWidth = mlpPkg::accWidth;
	localparam int actWidth = mlpPkg::featureWidth;

	// limits of the 8-bit result, held at accumulator width for the compares
	localparam logic signed [accWidth-1:0] actMax = 2 ** (actWidth - 1) - 1;
	localparam logic signed [accWidth-1:0] actMin = -(2 ** (actWidth - 1));

	// the bias is given in output units so it is lifted to the product scale
	localparam logic signed [accWidth-1:0] biasTerm = accWidth'(bias) <<< scaleShift;

	mlpPkg::fixedVal [fanIn-1:0] inReg;
	logic signed [accWidth-1:0] sumNext;
	logic signed [accWidth-1:0] sumReg;
	logic signed [accWidth-1:0] scaled;
	logic signed [actWidth-1:0] actNext;

	// weighted sum of the registered inputs, every term sign extended first
	always_comb
	begin
		sumNext = biasTerm;
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + accWidth'(inReg[i]) * accWidth'(weights[i]);
		end
	end

	assign scaled = sumReg >>> scaleShift; // arithmetic shift keeps the sign of the full sum

	always_comb
	begin
		if (useClamp)
		begin
			// the decision looks at the whole sum, not at one bit of it
			if (scaled < 0)
			begin
				actNext = '0;
			end
			else if (scaled > actMax)
			begin
				actNext = actWidth'(actMax);
			end
			else
			begin
				actNext = actWidth'(scaled);
			end
		end
		else
		begin
			if (scaled > actMax)
			begin
				actNext = actWidth'(actMax);
			end
			else if (scaled < actMin)
			begin
				actNext = actWidth'(actMin); // most negative code
			end
			else
			begin
				actNext = actWidth'(scaled);
			end
		end
	end

	// three stages: inputs, sum, activated result
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inReg <= inputs;
			sumReg <= sumNext;
			activation <= actNext;
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tbMlp -o simMlp \
	&& ./obj_dir/simMlp | tee /dev/stderr | grep -q '^>>> PASS$' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb.f ====
mlpPkg.sv
neuronNode.sv
denseLayer.sv
argmaxSelect.sv
mlpClassifier.sv
mlpChecker.sv
tbMlp.sv

// ==== tbMlp.sv ====
`timescale 1ns/1ps

module tbMlp;

	localparam int resetCycles = 3;
	localparam int latency = 7;
	localparam int timeoutMargin = 20;
	localparam int maxVectors = 64;

	// 15 features, 4 scores and the class on every line of the stim file
	localparam int fieldsPerLine = mlpPkg::numFeatures + mlpPkg::numClasses + 1;
	localparam int memSize = maxVectors * fieldsPerLine;

	logic clk;
	logic reset;
	mlpPkg::featureVec features;
	mlpPkg::scoreVec scores;
	logic [mlpPkg::classIndexWidth-1:0] classIndex;

	logic expValid;
	mlpPkg::scoreVec expScores;
	logic [mlpPkg::classIndexWidth-1:0] expClass;
	logic reportNow;
	int checkedCount;
	int errorCount;

	logic [7:0] stimMem [0:memSize-1];
	int numVectors;
	int cycleCount;
	int cycleLimit;

	mlpClassifier i_mlpClassifier (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIndex(classIndex)
	);

	mlpChecker #(
		.latency(latency)
	) i_mlpChecker (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIndex(classIndex),
		.expValid(expValid),
		.expScores(expScores),
		.expClass(expClass),
		.reportNow(reportNow),
		.checkedCount(checkedCount),
		.errorCount(errorCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// unused entries keep a fill whose class column can never hold a valid class
	task automatic loadStimulus();
		int a;
		for (a = 0; a < memSize; a++)
		begin
			stimMem[a] = 8'h80 | 8'(a ^ (a >> 7));
		end
		$readmemh("mlpStim.mem", stimMem);
		numVectors = 0;
		while (numVectors < maxVectors
			&& stimMem[numVectors * fieldsPerLine + fieldsPerLine - 1] < 8'h04)
		begin
			numVectors++;
		end
	endtask

	task automatic applyVector(input int n);
		int base;
		base = n * fieldsPerLine;
		for (int i = 0; i < mlpPkg::numFeatures; i++)
		begin
			features.value[i] = stimMem[base + i];
		end
		for (int c = 0; c < mlpPkg::numClasses; c++)
		begin
			expScores.value[c] = stimMem[base + mlpPkg::numFeatures + c];
		end
		expClass = stimMem[base + fieldsPerLine - 1][mlpPkg::classIndexWidth-1:0];
		expValid = 1'b1;
	endtask

	initial
	begin
		reset = 1'b1;
		features = '0;
		expValid = 1'b0;
		expScores = '0;
		expClass = '0;
		reportNow = 1'b0;
		loadStimulus();
		cycleLimit = numVectors + resetCycles + latency + timeoutMargin;
		$display("loaded %0d vectors, limit %0d cycles", numVectors, cycleLimit);
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int n = 0; n < numVectors; n++)
		begin
			applyVector(n); // one new vector on every cycle
			@(posedge clk);
			#1;
		end
		features = '0;
		expValid = 1'b0;
		wait (checkedCount == numVectors + 1); // the reset check counts as a test too
		@(negedge clk);
		reportNow = 1'b1;
		#1;
		if (errorCount == 0 && numVectors > 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			if (numVectors == 0)
			begin
				$display("no test vectors were read from mlpStim.mem");
			end
			$display(">>> FAIL");
		end
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		#1;
		while (cycleCount <= cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, only %0d of %0d tests were checked", cycleCount,
			checkedCount, numVectors + 1);
		$display(">>> FAIL");
		$finish;
	end

endmodule
